/* design/core_pkg.sv */
// Shared RV32I front-end types and encodings with XLEN fixed at 32 and only base opcodes plus custom-0 known
package core_pkg;

  // ====================================================================
  // Word and field types
  // ====================================================================

  // Data, address and instruction word
  typedef logic [31:0] xlen_t;

  // Register index
  typedef logic [4:0] reg_addr_t;

  // Micro-op sent to the selected unit
  typedef logic [3:0] uop_t;

  // One-hot unit select with int, lsu and vec from bit 0 up
  typedef logic [2:0] unit_sel_t;

  // Major opcode and funct3 fields
  typedef logic [6:0] opcode_t;
  typedef logic [2:0] funct3_t;

  // ====================================================================
  // Opcodes
  // ====================================================================

  localparam opcode_t OPC_OP      = 7'b0110011;
  localparam opcode_t OPC_OP_IMM  = 7'b0010011;
  localparam opcode_t OPC_LUI     = 7'b0110111;
  localparam opcode_t OPC_AUIPC   = 7'b0010111;
  localparam opcode_t OPC_JAL     = 7'b1101111;
  localparam opcode_t OPC_JALR    = 7'b1100111;
  localparam opcode_t OPC_BRANCH  = 7'b1100011;
  localparam opcode_t OPC_LOAD    = 7'b0000011;
  localparam opcode_t OPC_STORE   = 7'b0100011;
  // Custom-0 space goes to the vector unit
  localparam opcode_t OPC_CUSTOM0 = 7'b0001011;

  // ====================================================================
  // Unit select codes and fetch FSM
  // ====================================================================

  localparam unit_sel_t UNIT_NONE = 3'b000;
  localparam unit_sel_t UNIT_INT  = 3'b001;
  localparam unit_sel_t UNIT_LSU  = 3'b010;
  localparam unit_sel_t UNIT_VEC  = 3'b100;

  // Fetch control states
  typedef enum logic [1:0] {
    FETCH_RESET,
    FETCH_RUN,
    FETCH_HALTED
  } fetch_state_t;

endpackage

/* design/fetch_unit.sv */
// Sequential fetch only with no branch redirect and an instruction memory answering in the same cycle
module fetch_unit #(
  parameter core_pkg::xlen_t RESET_PC = '0
) (
  input  logic            clock_in,
  input  logic            arst_n,
  input  logic            halt_in,
  input  core_pkg::xlen_t ins_data,
  output core_pkg::xlen_t ins_mem_addr,
  output logic            if_valid,
  output core_pkg::xlen_t if_instr,
  output core_pkg::xlen_t if_pc
);

  core_pkg::fetch_state_t state;
  core_pkg::fetch_state_t state_next;
  core_pkg::xlen_t        pc;
  logic                   fetch_en;

  // ====================================================================
  // Halt FSM
  // ====================================================================

  always_comb begin
    state_next = state;
    case (state)
      // First edge out of reset never captures
      core_pkg::FETCH_RESET: begin
        state_next = halt_in ? core_pkg::FETCH_HALTED : core_pkg::FETCH_RUN;
      end
      core_pkg::FETCH_RUN: begin
        if (halt_in) begin
          state_next = core_pkg::FETCH_HALTED;
        end
      end
      // Release edge only rearms, capture restarts on the next edge
      core_pkg::FETCH_HALTED: begin
        if (!halt_in) begin
          state_next = core_pkg::FETCH_RUN;
        end
      end
      default: state_next = core_pkg::FETCH_RESET;
    endcase
  end

  // Capture only while running and not being halted at this edge
  assign fetch_en = (state == core_pkg::FETCH_RUN) && !halt_in;

  always_ff @(posedge clock_in or negedge arst_n) begin
    if (!arst_n) begin
      state <= core_pkg::FETCH_RESET;
    end else begin
      state <= state_next;
    end
  end

  // ====================================================================
  // Program counter
  // ====================================================================

  // PC held whenever nothing is captured
  always_ff @(posedge clock_in or negedge arst_n) begin
    if (!arst_n) begin
      pc <= RESET_PC;
    end else if (fetch_en) begin
      pc <= pc + 32'd4;
    end
  end

  // Memory sees the live PC
  assign ins_mem_addr = pc;

  // ====================================================================
  // IF/ID stage
  // ====================================================================

  // Word and its own PC latched together
  always_ff @(posedge clock_in or negedge arst_n) begin
    if (!arst_n) begin
      if_valid <= 1'b0;
      if_instr <= '0;
      if_pc    <= '0;
    end else begin
      if_valid <= fetch_en;
      if (fetch_en) begin
        if_instr <= ins_data;
        if_pc    <= pc;
      end
    end
  end

endmodule

/* design/gpr_file.sv */
// 32 x 32-bit GPRs with x0 fixed at zero and a same-cycle bypass from the single write port
module gpr_file (
  input  logic                clock_in,
  input  logic                arst_n,
  input  core_pkg::reg_addr_t rs1_addr,
  input  core_pkg::reg_addr_t rs2_addr,
  input  logic                wb_enable,
  input  core_pkg::reg_addr_t wb_addr,
  input  core_pkg::xlen_t     wb_data,
  output core_pkg::xlen_t     rs1_data,
  output core_pkg::xlen_t     rs2_data
);

  // x0 has no storage
  core_pkg::xlen_t regs [1:31];

  // Read port with x0 and bypass handling
  function automatic core_pkg::xlen_t read_port(input core_pkg::reg_addr_t addr);
    core_pkg::xlen_t value;
    if (addr == 5'd0) begin
      value = '0;
    end else if (wb_enable && (wb_addr == addr)) begin
      // Forward the word being written this cycle
      value = wb_data;
    end else begin
      value = regs[addr];
    end
    return value;
  endfunction

  // Asynchronous reads, re-evaluated on storage and write-port changes too
  always_comb begin
    rs1_data = read_port(rs1_addr);
    rs2_data = read_port(rs2_addr);
  end

  // ====================================================================
  // Write port
  // ====================================================================

  // Writes to x0 dropped
  always_ff @(posedge clock_in or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wb_enable && (wb_addr != 5'd0)) begin
      regs[wb_addr] <= wb_data;
    end
  end

endmodule

/* design/decode_unit.sv */
// Single-cycle RV32I decode into ID/IS with custom-0 taking an I-type immediate and no hazard checks
module decode_unit (
  input  logic                  clock_in,
  input  logic                  arst_n,
  input  logic                  if_valid,
  input  core_pkg::xlen_t       if_instr,
  input  core_pkg::xlen_t       if_pc,
  input  core_pkg::xlen_t       rs1_data,
  input  core_pkg::xlen_t       rs2_data,
  output logic                  issue_valid,
  output core_pkg::unit_sel_t   unit_sel,
  output core_pkg::uop_t        uop,
  output core_pkg::xlen_t       operand_a,
  output core_pkg::xlen_t       operand_b,
  output core_pkg::xlen_t       imm_value,
  output core_pkg::xlen_t       issue_pc,
  output core_pkg::reg_addr_t   rd_addr,
  output logic                  invalid_ins
);

  core_pkg::opcode_t   opcode;
  core_pkg::funct3_t   funct3;
  logic                alt_bit;
  core_pkg::xlen_t     imm_i;
  core_pkg::xlen_t     imm_s;
  core_pkg::xlen_t     imm_b;
  core_pkg::xlen_t     imm_u;
  core_pkg::xlen_t     imm_j;
  core_pkg::unit_sel_t unit_d;
  core_pkg::uop_t      uop_d;
  core_pkg::xlen_t     imm_d;
  logic                invalid_d;
  logic                a_from_pc;
  logic                a_zero;
  logic                b_from_rs2;
  logic                rd_none;
  core_pkg::xlen_t     op_a_d;
  core_pkg::xlen_t     op_b_d;
  core_pkg::reg_addr_t rd_d;

  // ====================================================================
  // Field extraction and immediates
  // ====================================================================

  assign opcode  = if_instr[6:0];
  assign funct3  = if_instr[14:12];
  // funct7 bit 5 picks SUB and SRA
  assign alt_bit = if_instr[30];

  // All formats sign-extended from bit 31
  assign imm_i = {{20{if_instr[31]}}, if_instr[31:20]};
  assign imm_s = {{20{if_instr[31]}}, if_instr[31:25], if_instr[11:7]};
  assign imm_b = {{19{if_instr[31]}}, if_instr[31], if_instr[7], if_instr[30:25],
                  if_instr[11:8], 1'b0};
  assign imm_u = {if_instr[31:12], 12'h000};
  assign imm_j = {{11{if_instr[31]}}, if_instr[31], if_instr[19:12], if_instr[20],
                  if_instr[30:21], 1'b0};

  // ====================================================================
  // Opcode decode
  // ====================================================================

  always_comb begin
    unit_d     = core_pkg::UNIT_INT;
    uop_d      = {1'b0, funct3};
    imm_d      = imm_i;
    invalid_d  = 1'b0;
    a_from_pc  = 1'b0;
    a_zero     = 1'b0;
    b_from_rs2 = 1'b0;
    rd_none    = 1'b0;
    case (opcode)
      // Register-register ALU op, no immediate
      core_pkg::OPC_OP: begin
        uop_d      = {alt_bit, funct3};
        imm_d      = '0;
        b_from_rs2 = 1'b1;
      end
      // Only the right shifts carry the alt bit
      core_pkg::OPC_OP_IMM: begin
        if (funct3 == 3'd5) begin
          uop_d = {alt_bit, funct3};
        end
      end
      core_pkg::OPC_LUI: begin
        uop_d  = 4'd0;
        imm_d  = imm_u;
        a_zero = 1'b1;
      end
      core_pkg::OPC_AUIPC: begin
        uop_d     = 4'd1;
        imm_d     = imm_u;
        a_from_pc = 1'b1;
      end
      core_pkg::OPC_JAL: begin
        uop_d     = 4'd2;
        imm_d     = imm_j;
        a_from_pc = 1'b1;
      end
      core_pkg::OPC_JALR: begin
        uop_d = 4'd3;
      end
      // Compare rs1 against rs2, no destination
      core_pkg::OPC_BRANCH: begin
        imm_d      = imm_b;
        b_from_rs2 = 1'b1;
        rd_none    = 1'b1;
      end
      core_pkg::OPC_LOAD: begin
        unit_d = core_pkg::UNIT_LSU;
      end
      // Store data rides on operand b
      core_pkg::OPC_STORE: begin
        unit_d     = core_pkg::UNIT_LSU;
        uop_d      = {1'b1, funct3};
        imm_d      = imm_s;
        b_from_rs2 = 1'b1;
        rd_none    = 1'b1;
      end
      core_pkg::OPC_CUSTOM0: begin
        unit_d = core_pkg::UNIT_VEC;
      end
      // Unknown opcode
      default: begin
        unit_d    = core_pkg::UNIT_NONE;
        uop_d     = 4'd0;
        imm_d     = '0;
        invalid_d = 1'b1;
      end
    endcase
  end

  // Operand muxes
  assign op_a_d = a_zero ? '0 : (a_from_pc ? if_pc : rs1_data);
  assign op_b_d = b_from_rs2 ? rs2_data : imm_d;
  assign rd_d   = rd_none ? 5'd0 : if_instr[11:7];

  // ====================================================================
  // ID/IS stage
  // ====================================================================

  // Bubbles register with no unit enabled
  always_ff @(posedge clock_in or negedge arst_n) begin
    if (!arst_n) begin
      issue_valid <= 1'b0;
      unit_sel    <= core_pkg::UNIT_NONE;
      invalid_ins <= 1'b0;
      uop         <= '0;
      operand_a   <= '0;
      operand_b   <= '0;
      imm_value   <= '0;
      issue_pc    <= '0;
      rd_addr     <= '0;
    end else begin
      issue_valid <= if_valid;
      unit_sel    <= if_valid ? unit_d : core_pkg::UNIT_NONE;
      invalid_ins <= if_valid & invalid_d;
      uop         <= uop_d;
      operand_a   <= op_a_d;
      operand_b   <= op_b_d;
      imm_value   <= imm_d;
      issue_pc    <= if_pc;
      rd_addr     <= rd_d;
    end
  end

endmodule

/* design/core_frontend_top.sv */
// RV32I front end from fetch to issue with external instruction memory and writeback and no stalls but halt
module core_frontend_top #(
  parameter core_pkg::xlen_t RESET_PC = '0
) (
  input  logic                clock_in,
  input  logic                arst_n,
  input  logic                halt_in,
  input  core_pkg::xlen_t     ins_data,
  input  logic                wb_enable,
  input  core_pkg::reg_addr_t wb_addr,
  input  core_pkg::xlen_t     wb_data,
  output core_pkg::xlen_t     ins_mem_addr,
  output logic                issue_valid,
  output core_pkg::unit_sel_t unit_sel,
  output core_pkg::uop_t      uop,
  output core_pkg::xlen_t     operand_a,
  output core_pkg::xlen_t     operand_b,
  output core_pkg::xlen_t     imm_value,
  output core_pkg::xlen_t     issue_pc,
  output core_pkg::reg_addr_t rd_addr,
  output logic                invalid_ins
);

  // IF/ID outputs
  logic            if_valid;
  core_pkg::xlen_t if_instr;
  core_pkg::xlen_t if_pc;

  // Register read data
  core_pkg::xlen_t rs1_data;
  core_pkg::xlen_t rs2_data;

  // ====================================================================
  // Fetch
  // ====================================================================

  fetch_unit #(
    .RESET_PC (RESET_PC)
  ) u_fetch (
    .clock_in     (clock_in),
    .arst_n       (arst_n),
    .halt_in      (halt_in),
    .ins_data     (ins_data),
    .ins_mem_addr (ins_mem_addr),
    .if_valid     (if_valid),
    .if_instr     (if_instr),
    .if_pc        (if_pc)
  );

  // ====================================================================
  // Register file and decode/issue
  // ====================================================================

  // Source indices straight from the IF/ID word
  gpr_file u_gpr (
    .clock_in  (clock_in),
    .arst_n    (arst_n),
    .rs1_addr  (if_instr[19:15]),
    .rs2_addr  (if_instr[24:20]),
    .wb_enable (wb_enable),
    .wb_addr   (wb_addr),
    .wb_data   (wb_data),
    .rs1_data  (rs1_data),
    .rs2_data  (rs2_data)
  );

  decode_unit u_decode (
    .clock_in    (clock_in),
    .arst_n      (arst_n),
    .if_valid    (if_valid),
    .if_instr    (if_instr),
    .if_pc       (if_pc),
    .rs1_data    (rs1_data),
    .rs2_data    (rs2_data),
    .issue_valid (issue_valid),
    .unit_sel    (unit_sel),
    .uop         (uop),
    .operand_a   (operand_a),
    .operand_b   (operand_b),
    .imm_value   (imm_value),
    .issue_pc    (issue_pc),
    .rd_addr     (rd_addr),
    .invalid_ins (invalid_ins)
  );

endmodule

/* test/tb_clock_gen.sv */
// Free-running 8 ns clock with reset held low for the first 10 rising edges and released by NBA
module tb_clock_gen (
  output logic clock_in,
  output logic arst_n
);
  timeunit 1ns;
  timeprecision 100ps;

  // 4 ns half period
  initial begin
    clock_in = 1'b0;
    forever #4 clock_in = ~clock_in;
  end

  // Release lands on the 10th rising edge, so that edge still resets
  initial begin
    arst_n = 1'b0;
    repeat (10) @(posedge clock_in);
    arst_n <= 1'b1;
  end

endmodule

/* test/core_frontend_sva.sv */
// Issue and fetch-control checks, bound into the front-end top with the FSM state taken from u_fetch
module core_frontend_sva (
  input logic                   clock_in,
  input logic                   arst_n,
  input core_pkg::fetch_state_t state,
  input core_pkg::xlen_t        ins_mem_addr,
  input logic                   if_valid,
  input logic                   issue_valid,
  input core_pkg::unit_sel_t    unit_sel,
  input logic                   invalid_ins
);
  timeunit 1ns;
  timeprecision 100ps;

  // ====================================================================
  // Issue outputs
  // ====================================================================

  // At most one unit enabled
  a_unit_onehot: assert property (@(posedge clock_in) disable iff (!arst_n)
    $onehot0(unit_sel)) else $error("unit_sel has more than one bit set");

  // Illegal opcode reaches no unit
  a_invalid_no_unit: assert property (@(posedge clock_in) disable iff (!arst_n)
    invalid_ins |-> (unit_sel == '0)) else $error("invalid_ins with a unit selected");

  // Bubbles enable nothing
  a_bubble_no_unit: assert property (@(posedge clock_in) disable iff (!arst_n)
    !issue_valid |-> (unit_sel == '0)) else $error("unit selected without issue_valid");

  // ====================================================================
  // Fetch control
  // ====================================================================

  // PC frozen while halted
  a_halt_pc_stable: assert property (@(posedge clock_in) disable iff (!arst_n)
    (state == core_pkg::FETCH_HALTED) |-> $stable(ins_mem_addr))
    else $error("fetch address moved while halted");

  // No capture while halted
  a_halt_no_valid: assert property (@(posedge clock_in) disable iff (!arst_n)
    (state == core_pkg::FETCH_HALTED) |-> !if_valid)
    else $error("if_valid high while halted");

endmodule

/* test/core_frontend_tb.sv */
// Needs RESET_PC 0x100 on the DUT; the memory model covers 64 words and the table has 15 rows
module core_frontend_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam core_pkg::xlen_t RESET_PC  = 32'h0000_0100;
  localparam int              NUM_ROWS  = 15;
  localparam int              MEM_WORDS = 64;

  logic                clock_in;
  logic                arst_n;
  logic                halt_in;
  core_pkg::xlen_t     ins_data;
  logic                wb_enable;
  core_pkg::reg_addr_t wb_addr;
  core_pkg::xlen_t     wb_data;
  core_pkg::xlen_t     ins_mem_addr;
  logic                issue_valid;
  core_pkg::unit_sel_t unit_sel;
  core_pkg::uop_t      uop;
  core_pkg::xlen_t     operand_a;
  core_pkg::xlen_t     operand_b;
  core_pkg::xlen_t     imm_value;
  core_pkg::xlen_t     issue_pc;
  core_pkg::reg_addr_t rd_addr;
  logic                invalid_ins;

  // Instruction memory and register shadow
  core_pkg::xlen_t imem [0:MEM_WORDS-1];
  core_pkg::xlen_t shadow [0:31];

  // Stimulus and expectation table
  string               row_name [NUM_ROWS];
  core_pkg::xlen_t     row_instr [NUM_ROWS];
  core_pkg::unit_sel_t row_unit [NUM_ROWS];
  core_pkg::uop_t      row_uop [NUM_ROWS];
  core_pkg::xlen_t     row_imm [NUM_ROWS];
  core_pkg::xlen_t     row_a [NUM_ROWS];
  core_pkg::xlen_t     row_b [NUM_ROWS];
  core_pkg::reg_addr_t row_rd [NUM_ROWS];
  logic                row_invalid [NUM_ROWS];

  int row_count    = 0;
  int rows_checked = 0;
  int pass_count   = 0;
  int fail_count   = 0;

  tb_clock_gen u_clock (.*);

  core_frontend_top #(.RESET_PC(RESET_PC)) i_dut (.*);

  // Assertions across the fetch and decode stages
  bind core_frontend_top core_frontend_sva u_sva (.clock_in(clock_in), .arst_n(arst_n),
    .state(u_fetch.state), .ins_mem_addr(ins_mem_addr), .if_valid(if_valid),
    .issue_valid(issue_valid), .unit_sel(unit_sel), .invalid_ins(invalid_ins));

  // Combinational word read, one word per 4-byte step from RESET_PC
  assign ins_data = imem[(ins_mem_addr - RESET_PC) >> 2];

  function automatic core_pkg::xlen_t row_pc(input int idx);
    return RESET_PC + 4 * idx;
  endfunction

  // ====================================================================
  // Table and checking helpers
  // ====================================================================

  task automatic add_row(input string name, input core_pkg::xlen_t instr,
                         input core_pkg::unit_sel_t unit, input core_pkg::uop_t op,
                         input core_pkg::xlen_t imm, input core_pkg::xlen_t a,
                         input core_pkg::xlen_t b, input core_pkg::reg_addr_t rd,
                         input logic invalid);
    row_name[row_count]    = name;
    row_instr[row_count]   = instr;
    row_unit[row_count]    = unit;
    row_uop[row_count]     = op;
    row_imm[row_count]     = imm;
    row_a[row_count]       = a;
    row_b[row_count]       = b;
    row_rd[row_count]      = rd;
    row_invalid[row_count] = invalid;
    imem[row_count]        = instr;
    row_count++;
  endtask

  task automatic check_field(input string test, input string field,
                             input core_pkg::xlen_t expected, input core_pkg::xlen_t actual,
                             inout bit ok);
    if (actual !== expected) begin
      $display("MISMATCH %s %s: expected %h, actual %h", test, field, expected, actual);
      ok = 1'b0;
    end
  endtask

  task automatic report_test(input string name, input bit ok);
    if (ok) begin
      $display("PASS %s", name);
      pass_count++;
    end else begin
      $display("FAIL %s", name);
      fail_count++;
    end
  endtask

  // Hand-encoded words, expectations from the decode rules and the shadow
  task automatic build_table();
    add_row("add", 32'h002081B3, 3'b001, 4'h0, 32'h0, shadow[1], shadow[2], 5'd3, 1'b0);
    add_row("sub_x0", 32'h40028233, 3'b001, 4'h8, 32'h0, shadow[5], shadow[0], 5'd4, 1'b0);
    add_row("addi_neg", 32'hFFB38313, 3'b001, 4'h0, 32'hFFFF_FFFB, shadow[7],
            32'hFFFF_FFFB, 5'd6, 1'b0);
    add_row("srli", 32'h0034D413, 3'b001, 4'h5, 32'h3, shadow[9], 32'h3, 5'd8, 1'b0);
    add_row("srai", 32'h4075D513, 3'b001, 4'hD, 32'h407, shadow[11], 32'h407, 5'd10, 1'b0);
    add_row("lui", 32'h80001637, 3'b001, 4'h0, 32'h8000_1000, 32'h0, 32'h8000_1000,
            5'd12, 1'b0);
    add_row("auipc", 32'h12345697, 3'b001, 4'h1, 32'h1234_5000, row_pc(6), 32'h1234_5000,
            5'd13, 1'b0);
    add_row("jal_neg", 32'hFF9FF0EF, 3'b001, 4'h2, 32'hFFFF_FFF8, row_pc(7), 32'hFFFF_FFF8,
            5'd1, 1'b0);
    add_row("jalr", 32'h01078767, 3'b001, 4'h3, 32'h10, shadow[15], 32'h10, 5'd14, 1'b0);
    add_row("bne_neg", 32'hFF181EE3, 3'b001, 4'h1, 32'hFFFF_FFFC, shadow[16], shadow[17],
            5'd0, 1'b0);
    add_row("lw_neg", 32'hFF49A903, 3'b010, 4'h2, 32'hFFFF_FFF4, shadow[19], 32'hFFFF_FFF4,
            5'd18, 1'b0);
    add_row("sw_neg", 32'hFF5A2023, 3'b010, 4'hA, 32'hFFFF_FFE0, shadow[20], shadow[21],
            5'd0, 1'b0);
    add_row("custom0", 32'h05ABEB0B, 3'b100, 4'h6, 32'h5A, shadow[23], 32'h5A, 5'd22, 1'b0);
    // Opcode 7'h7F is unused
    add_row("illegal_zero", 32'h0000007F, 3'b000, 4'h0, 32'h0, 32'h0, 32'h0, 5'd0, 1'b1);
    add_row("illegal_ones", 32'hFFFFFFFF, 3'b000, 4'h0, 32'h0, shadow[31], 32'h0, 5'd31, 1'b1);
  endtask

  // ====================================================================
  // Issue checker and halt sequence
  // ====================================================================

  // Rows expected in order, so a skipped or repeated PC shows up as a mismatch
  task automatic check_issues();
    bit ok;
    while (rows_checked < NUM_ROWS) begin
      @(negedge clock_in);
      if (issue_valid) begin
        ok = 1'b1;
        check_field(row_name[rows_checked], "issue_pc", row_pc(rows_checked), issue_pc, ok);
        check_field(row_name[rows_checked], "unit_sel", row_unit[rows_checked], unit_sel, ok);
        check_field(row_name[rows_checked], "uop", row_uop[rows_checked], uop, ok);
        check_field(row_name[rows_checked], "imm_value", row_imm[rows_checked], imm_value, ok);
        check_field(row_name[rows_checked], "operand_a", row_a[rows_checked], operand_a, ok);
        check_field(row_name[rows_checked], "operand_b", row_b[rows_checked], operand_b, ok);
        check_field(row_name[rows_checked], "rd_addr", row_rd[rows_checked], rd_addr, ok);
        check_field(row_name[rows_checked], "invalid_ins", row_invalid[rows_checked],
                    invalid_ins, ok);
        report_test(row_name[rows_checked], ok);
        rows_checked++;
      end
    end
  endtask

  // Halt raised mid-program for several cycles
  task automatic halt_sequence();
    bit              ok;
    core_pkg::xlen_t held_addr;
    ok = 1'b1;
    wait (rows_checked >= 5);
    @(posedge clock_in);
    halt_in <= 1'b1;
    // First edge that samples halt_in high
    @(posedge clock_in);
    @(negedge clock_in);
    held_addr = ins_mem_addr;
    for (int i = 0; i < 4; i++) begin
      @(negedge clock_in);
      // Two edges after the halt the last issued word has drained
      if (i == 0 && issue_valid) begin
        $display("Halt: issue_valid still high two edges after halt_in was raised");
        ok = 1'b0;
      end
      check_field("halt_hold", "ins_mem_addr", held_addr, ins_mem_addr, ok);
    end
    @(posedge clock_in);
    halt_in <= 1'b0;
    report_test("halt_hold", ok);
  endtask

  // ====================================================================
  // Main sequence
  // ====================================================================

  initial begin
    bit              ok;
    core_pkg::xlen_t value;
    void'($urandom(32'hd14c_389a));
    halt_in   <= 1'b1;
    wb_enable <= 1'b0;
    wb_addr   <= '0;
    wb_data   <= '0;
    // Illegal opcode tagged with the word index
    for (int i = 0; i < MEM_WORDS; i++) begin
      imem[i] = {i[24:0], 7'h7F};
    end
    wait (arst_n === 1'b1);
    #1;
    ok = 1'b1;
    check_field("reset_state", "issue_valid", '0, issue_valid, ok);
    check_field("reset_state", "unit_sel", '0, unit_sel, ok);
    check_field("reset_state", "ins_mem_addr", RESET_PC, ins_mem_addr, ok);
    report_test("reset_state", ok);
    // Preload x0..x31 while fetch is halted, x0 write must be dropped
    for (int r = 0; r < 32; r++) begin
      value = $urandom();
      @(posedge clock_in);
      wb_enable <= 1'b1;
      wb_addr   <= r[4:0];
      wb_data   <= value;
      shadow[r] = (r == 0) ? '0 : value;
    end
    @(posedge clock_in);
    wb_enable <= 1'b0;
    build_table();
    halt_in <= 1'b0;
    fork
      check_issues();
      halt_sequence();
    join
    $display("Summary: %0d passed, %0d failed", pass_count, fail_count);
    if (fail_count == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  // Reset, preload, two cycles per row and margin
  initial begin
    #((10 + 32 + NUM_ROWS * 2 + 40) * 8);
    $display("Timeout: not every table row was issued before the time limit");
    $display("Test failed");
    $finish;
  end

endmodule

/* flist.f */
design/core_pkg.sv
design/fetch_unit.sv
design/gpr_file.sv
design/decode_unit.sv
design/core_frontend_top.sv
test/tb_clock_gen.sv
test/core_frontend_sva.sv
test/core_frontend_tb.sv
